// File: core_top.f
+incdir+verification
logic/core_pkg.sv
logic/core_settings_if.sv
logic/host_bridge_regs.sv
logic/reset_stretcher.sv
logic/video_out_stage.sv
logic/core_top.sv
verification/tb_core_top.sv

// File: Bender.yml
package:
  name: core_top

sources:
  - logic/core_pkg.sv
  - logic/core_settings_if.sv
  - logic/host_bridge_regs.sv
  - logic/reset_stretcher.sv
  - logic/video_out_stage.sv
  - logic/core_top.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/tb_core_top.sv

// File: verification/core_model.svh
// Reference model of the shell's register decode, data table word and slot tag.
// Included inside the testbench module, which must import core_pkg first.

`ifndef core_model_svh
`define core_model_svh

// model copies of the bridge registers
logic [1:0] exp_system = 2'd0;
logic [1:0] exp_flickerblend = 2'd0;
logic [1:0] exp_orientation = 2'd0;
logic       exp_cpu_turbo = 1'b0;
logic       exp_triple_buffer = 1'b0;
logic       exp_flip_horizontal = 1'b0;
logic       exp_fastforward_sound = 1'b0;
logic       exp_cart_download = 1'b0;
logic       exp_is_color = 1'b0;
logic       exp_bw_bios = 1'b0;
logic       exp_color_bios = 1'b0;
logic       exp_save_download = 1'b0;

// full address match, anything else is ignored
function automatic void apply_write(input bridge_addr_t addr, input bridge_data_t data);
  case (addr)
    reg_cart_download:     exp_cart_download = data[0];
    reg_is_color_cart:     exp_is_color = data[0];
    reg_bw_bios:           exp_bw_bios = data[0];
    reg_color_bios:        exp_color_bios = data[0];
    reg_save_download:     exp_save_download = data[0];
    reg_system:            exp_system = data[1:0];
    reg_cpu_turbo:         exp_cpu_turbo = data[0];
    reg_triple_buffer:     exp_triple_buffer = data[0];
    reg_flickerblend:      exp_flickerblend = data[1:0];
    reg_orientation:       exp_orientation = data[1:0];
    reg_flip_horizontal:   exp_flip_horizontal = data[0];
    reg_fastforward_sound: exp_fastforward_sound = data[0];
    default: ;
  endcase
endfunction

// same field order as the testbench's packed view of the outputs
function automatic logic [14:0] settings_word();
  logic [1:0] cart_sel;
  cart_sel = 2'b00;
  if (exp_cart_download) begin
    cart_sel = exp_is_color ? 2'b10 : 2'b01;
  end
  return {exp_system, exp_cpu_turbo, exp_triple_buffer, exp_flickerblend, exp_orientation,
          exp_flip_horizontal, exp_fastforward_sound, cart_sel, exp_color_bios, exp_bw_bios,
          exp_save_download};
endfunction

// bit 13 set for vertical, auto follows the core hint
function automatic rgb_t slot_tag_for(input logic [1:0] orient, input logic vert);
  rgb_t tag;
  tag = '0;
  tag[13] = (orient == 2'd2) || ((orient == 2'd0) && vert);
  return tag;
endfunction

function automatic bridge_data_t table_word_for(input save_blocks_t blocks);
  return {20'd0, blocks} * 32'd512;
endfunction

`endif

// File: verification/tb_core_top.sv
// Testbench for the host shell, with the core reset shortened to 64 cycles.
// Video checks run every cycle once the shell is out of reset.
// Random stimulus is repeatable from a fixed seed.

`timescale 1ns/1ns

module tb_core_top
  import core_pkg::*;
();

  localparam int reset_len = 64;
  localparam int hs_delay  = 7;
  localparam bridge_addr_t mapped_regs [12] = '{
    reg_cart_download, reg_is_color_cart, reg_bw_bios, reg_color_bios,
    reg_save_download, reg_system, reg_cpu_turbo, reg_triple_buffer,
    reg_flickerblend, reg_orientation, reg_flip_horizontal, reg_fastforward_sound
  };

  logic          clk_74a;
  logic          pll_core_locked;
  bridge_addr_t  bridge_addr;
  logic          bridge_wr;
  bridge_data_t  bridge_wr_data;
  save_blocks_t  save_size;
  logic          core_hblank;
  logic          core_vblank;
  logic          core_hsync;
  logic          core_vsync;
  rgb_t          core_rgb;
  logic          core_is_vertical;
  logic          datatable_wren;
  bridge_data_t  datatable_data;
  logic [1:0]    cart_download_sel;
  logic [1:0]    bios_download;
  logic          save_download;
  logic          core_reset;
  system_e       system;
  logic          cpu_turbo;
  logic          triple_buffer;
  flickerblend_e flickerblend;
  orientation_e  orientation;
  logic          flip_horizontal;
  logic          fastforward_sound;
  rgb_t          video_rgb;
  logic          video_de;
  logic          video_hs;
  logic          video_vs;

  int errors = 0;
  int checks = 0;

  // video checker state, inputs as the DUT sampled them
  logic video_on = 1'b0;
  logic primed = 1'b0;
  logic s_hb;
  logic s_vb;
  logic s_hs;
  logic s_vs;
  logic s_vert;
  rgb_t s_rgb;
  logic last_de = 1'b0;
  logic last_hs = 1'b0;
  logic last_vs = 1'b0;
  int   edge_n = 0;
  int   hs_due = -100;

  `include "core_model.svh"

  core_top #(
    .reset_cycles (reset_len),
    .hsync_delay  (hs_delay)
  ) core_top_i (.*);

  always #2 clk_74a = ~clk_74a;

  task automatic flag_mismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
    errors++;
    $display("ERROR %0t: %s is %0h, expected %0h", $time, what, got, exp);
  endtask

  task automatic check_settings(input string when_text);
    logic [14:0] got;
    got = {system, cpu_turbo, triple_buffer, flickerblend, orientation, flip_horizontal,
           fastforward_sound, cart_download_sel, bios_download, save_download};
    checks++;
    if (got !== settings_word()) flag_mismatch(when_text, got, settings_word());
  endtask

  // one write strobe, checked after the edge that takes it
  task automatic bridge_write(input bridge_addr_t addr, input bridge_data_t data);
    @(posedge clk_74a);
    bridge_addr    <= addr;
    bridge_wr      <= 1'b1;
    bridge_wr_data <= data;
    @(posedge clk_74a);
    bridge_wr <= 1'b0;
    apply_write(addr, data);
    @(negedge clk_74a);
    check_settings($sformatf("settings after write to %0h", addr));
  endtask

  task automatic reset_length(output int len);
    len = 0;
    while (core_reset === 1'b1 && len < 4 * reset_len) begin
      len++;
      @(negedge clk_74a);
    end
    if (core_reset === 1'b1) begin
      errors++;
      $display("core_reset did not fall within %0d cycles", 4 * reset_len);
    end
  endtask

  task automatic idle_video();
    @(posedge clk_74a);
    core_hblank <= 1'b1;
    core_vblank <= 1'b1;
    core_hsync  <= 1'b0;
    core_vsync  <= 1'b0;
    repeat (10) @(posedge clk_74a);
  endtask

  ////////////////////////////////////////
  // video checker

  always @(negedge clk_74a) begin : video_check
    logic exp_de;
    rgb_t exp_rgb;
    if (video_on) begin
      if (primed) begin
        edge_n++;
        exp_de = !(s_hb || s_vb);
        if (exp_de) exp_rgb = s_rgb;
        else if (last_de) exp_rgb = slot_tag_for(exp_orientation, s_vert);
        else exp_rgb = '0;
        if (s_hs && !last_hs) hs_due = edge_n + hs_delay - 1;
        checks++;
        if ({video_de, video_rgb} !== {exp_de, exp_rgb})
          flag_mismatch("video de and rgb", {video_de, video_rgb}, {exp_de, exp_rgb});
        if (video_vs !== (s_vs && !last_vs)) flag_mismatch("video_vs", video_vs, s_vs && !last_vs);
        if (video_hs !== (edge_n == hs_due)) flag_mismatch("video_hs", video_hs, edge_n == hs_due);
        last_de = exp_de;
        last_hs = s_hs;
        last_vs = s_vs;
      end
      s_hb   = core_hblank;
      s_vb   = core_vblank;
      s_hs   = core_hsync;
      s_vs   = core_vsync;
      s_vert = core_is_vertical;
      s_rgb  = core_rgb;
      primed = 1'b1;
    end
  end

  ////////////////////////////////////////
  // main sequence

  initial begin : main_seq
    bridge_addr_t addr;
    int len;
    int hs_left;
    save_blocks_t prev_size;
    void'($urandom(50327));
    clk_74a          = 1'b0;
    pll_core_locked  = 1'b0;
    bridge_addr      = '0;
    bridge_wr        = 1'b0;
    bridge_wr_data   = '0;
    save_size        = '0;
    core_hblank      = 1'b1;
    core_vblank      = 1'b1;
    core_hsync       = 1'b0;
    core_vsync       = 1'b0;
    core_rgb         = '0;
    core_is_vertical = 1'b0;

    repeat (16) @(posedge clk_74a);
    pll_core_locked <= 1'b1;
    @(negedge clk_74a);
    checks++;
    if ({video_de, video_hs, video_vs, core_reset, datatable_wren} !== 5'b0)
      flag_mismatch("outputs after reset",
                    {video_de, video_hs, video_vs, core_reset, datatable_wren}, 0);
    check_settings("settings after reset");
    @(posedge clk_74a);
    @(negedge clk_74a);
    checks++;
    if (datatable_wren !== 1'b1) flag_mismatch("datatable_wren", datatable_wren, 1);
    @(posedge clk_74a);
    video_on = 1'b1;

    // random writes, some to unmapped addresses
    repeat (200) begin
      if ($urandom % 4 != 0) addr = mapped_regs[$urandom % 12];
      else addr = 32'h0000_1000 | $urandom;
      bridge_write(addr, $urandom);
    end

    // stretched reset, then a restart halfway
    checks++;
    if (core_reset !== 1'b0) flag_mismatch("core_reset before request", core_reset, 0);
    bridge_write(reg_core_reset, 32'h1);
    reset_length(len);
    checks++;
    if (len != reset_len) flag_mismatch("core_reset length", len, reset_len);
    bridge_write(reg_core_reset, 32'h1);
    repeat (20) begin
      @(negedge clk_74a);
      checks++;
      if (core_reset !== 1'b1) flag_mismatch("core_reset mid count", core_reset, 1);
    end
    bridge_write(reg_core_reset, 32'h1);
    reset_length(len);
    checks++;
    if (len != reset_len) flag_mismatch("core_reset length after restart", len, reset_len);

    // save size to bytes, one cycle behind the input
    repeat (20) begin
      @(posedge clk_74a);
      prev_size = save_size;
      save_size <= save_blocks_t'($urandom);
      @(negedge clk_74a);
      checks++;
      if (datatable_data !== table_word_for(prev_size))
        flag_mismatch("datatable_data before update", datatable_data,
                      table_word_for(prev_size));
      @(posedge clk_74a);
      @(negedge clk_74a);
      checks++;
      if (datatable_data !== table_word_for(save_size))
        flag_mismatch("datatable_data", datatable_data, table_word_for(save_size));
    end

    // random video, hsync rises 10 to 15 cycles apart
    hs_left = 3;
    repeat (400) begin
      @(posedge clk_74a);
      core_hblank      <= ($urandom % 4 == 0);
      core_vblank      <= ($urandom % 8 == 0);
      core_rgb         <= rgb_t'($urandom);
      core_is_vertical <= 1'($urandom);
      if ($urandom % 6 == 0) core_vsync <= ~core_vsync;
      core_hsync <= (hs_left == 0);
      if (hs_left == 0) hs_left = 9 + $urandom % 6;
      else hs_left--;
    end
    idle_video();

    // slot tag for every orientation and hint
    for (int o = 0; o < 3; o++) begin
      for (int v = 0; v < 2; v++) begin
        bridge_write(reg_orientation, o);
        @(posedge clk_74a);
        core_is_vertical <= 1'(v);
        core_hblank      <= 1'b0;
        core_vblank      <= 1'b0;
        core_rgb         <= rgb_t'($urandom);
        @(posedge clk_74a);
        core_hblank <= 1'b1;
        @(posedge clk_74a);
        core_vblank <= 1'b1;
        @(negedge clk_74a);
        checks++;
        if (video_rgb !== slot_tag_for(2'(o), 1'(v)))
          flag_mismatch($sformatf("slot tag for orientation %0d hint %0d", o, v),
                        video_rgb, slot_tag_for(2'(o), 1'(v)));
      end
    end

    repeat (4) @(posedge clk_74a);
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: logic/core_top.sv
// Host-facing shell of the emulator core, all on clk_74a.
// pll_core_locked low resets every block asynchronously.
// The data table address is the fixed save slot word and is not an output.

`timescale 1ns/1ns

module core_top
  import core_pkg::*;
#(
  parameter int reset_cycles = 1048576,
  parameter int hsync_delay  = 7
) (
  input  logic          clk_74a,
  input  logic          pll_core_locked,

  // bridge
  input  bridge_addr_t  bridge_addr,
  input  logic          bridge_wr,
  input  bridge_data_t  bridge_wr_data,

  // from the emulator core
  input  save_blocks_t  save_size,
  input  logic          core_hblank,
  input  logic          core_vblank,
  input  logic          core_hsync,
  input  logic          core_vsync,
  input  rgb_t          core_rgb,
  input  logic          core_is_vertical,

  // data table
  output logic          datatable_wren,
  output bridge_data_t  datatable_data,

  // downloads and reset
  output logic [1:0]    cart_download_sel,
  output logic [1:0]    bios_download,
  output logic          save_download,
  output logic          core_reset,

  // settings
  output system_e       system,
  output logic          cpu_turbo,
  output logic          triple_buffer,
  output flickerblend_e flickerblend,
  output orientation_e  orientation,
  output logic          flip_horizontal,
  output logic          fastforward_sound,

  // scaler video
  output rgb_t          video_rgb,
  output logic          video_de,
  output logic          video_hs,
  output logic          video_vs
);

  core_settings_if settings ();

  logic reset_request;

  ////////////////////////////////////////
  // bridge registers and core reset

  host_bridge_regs host_bridge_regs_i (
    .clk_74a           (clk_74a),
    .pll_core_locked   (pll_core_locked),
    .bridge_addr       (bridge_addr),
    .bridge_wr         (bridge_wr),
    .bridge_wr_data    (bridge_wr_data),
    .save_size         (save_size),
    .settings          (settings.regs),
    .reset_request     (reset_request),
    .cart_download_sel (cart_download_sel),
    .bios_download     (bios_download),
    .save_download     (save_download),
    .datatable_wren    (datatable_wren),
    .datatable_data    (datatable_data)
  );

  reset_stretcher #(
    .reset_cycles (reset_cycles)
  ) reset_stretcher_i (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .reset_request   (reset_request),
    .core_reset      (core_reset)
  );

  ////////////////////////////////////////
  // video to scaler

  video_out_stage #(
    .hsync_delay (hsync_delay)
  ) video_out_stage_i (
    .clk_74a          (clk_74a),
    .pll_core_locked  (pll_core_locked),
    .settings         (settings.sink),
    .core_hblank      (core_hblank),
    .core_vblank      (core_vblank),
    .core_hsync       (core_hsync),
    .core_vsync       (core_vsync),
    .core_rgb         (core_rgb),
    .core_is_vertical (core_is_vertical),
    .video_rgb        (video_rgb),
    .video_de         (video_de),
    .video_hs         (video_hs),
    .video_vs         (video_vs)
  );

  // settings out to the core
  assign system            = settings.system;
  assign cpu_turbo         = settings.cpu_turbo;
  assign triple_buffer     = settings.triple_buffer;
  assign flickerblend      = settings.flickerblend;
  assign orientation       = settings.orientation;
  assign flip_horizontal   = settings.flip_horizontal;
  assign fastforward_sound = settings.fastforward_sound;

endmodule

// File: logic/video_out_stage.sv
// Shapes raw core video into scaler timing, one cycle behind the inputs.
// hsync is delayed so it cannot overlap the vsync pulse; hsync rises must be
// further apart than hsync_delay cycles. hsync_delay must be at least 2.
// The first blank pixel carries the slot tag that selects the scaler orientation.

`timescale 1ns/1ns

module video_out_stage
  import core_pkg::*;
#(
  parameter int hsync_delay = 7
) (
  input  logic                 clk_74a,
  input  logic                 pll_core_locked,
  core_settings_if.sink        settings,
  input  logic                 core_hblank,
  input  logic                 core_vblank,
  input  logic                 core_hsync,
  input  logic                 core_vsync,
  input  rgb_t                 core_rgb,
  input  logic                 core_is_vertical,
  output rgb_t                 video_rgb,
  output logic                 video_de,
  output logic                 video_hs,
  output logic                 video_vs
);

  localparam int hs_w        = $clog2(hsync_delay);
  localparam int orient_bit  = 13;

  logic            de;
  logic            de_prev;
  logic            hs_prev;
  logic            vs_prev;
  logic            hs_rise;
  logic [hs_w-1:0] hs_count;
  logic            vertical;
  rgb_t            slot_tag;

  ////////////////////////////////////////
  // orientation and slot tag

  assign de      = ~(core_hblank | core_vblank);
  assign hs_rise = core_hsync & ~hs_prev;

  // auto follows the core's hint
  always_comb begin
    vertical = (settings.orientation == orient_vertical) ||
               ((settings.orientation == orient_auto) && core_is_vertical);
    slot_tag = '0;
    slot_tag[orient_bit] = vertical;
  end

  ////////////////////////////////////////
  // output registers

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_de  <= 1'b0;
      video_rgb <= '0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      de_prev   <= 1'b0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
      hs_count  <= '0;
    end else begin
      video_de <= de;

      if (de) begin
        video_rgb <= core_rgb;
      end else if (de_prev) begin
        // first blank pixel of the line
        video_rgb <= slot_tag;
      end else begin
        video_rgb <= '0;
      end

      // single-cycle vsync on the rising edge
      video_vs <= core_vsync & ~vs_prev;

      // delayed single-cycle hsync
      video_hs <= (hs_count == hs_w'(1));
      if (hs_rise) begin
        hs_count <= hs_w'(hsync_delay - 1);
      end else if (hs_count != '0) begin
        hs_count <= hs_count - 1'b1;
      end

      de_prev <= de;
      hs_prev <= core_hsync;
      vs_prev <= core_vsync;
    end
  end

endmodule

// File: logic/reset_stretcher.sv
// Long core reset started by a single-cycle host request.
// A new request during an active reset restarts the full count.
// reset_cycles must be at least 1.

`timescale 1ns/1ns

module reset_stretcher #(
  parameter int reset_cycles = 1048576
) (
  input  logic clk_74a,
  input  logic pll_core_locked,
  input  logic reset_request,
  output logic core_reset
);

  localparam int cnt_w = $clog2(reset_cycles + 1);

  logic [cnt_w-1:0] count;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      count <= '0;
    end else if (reset_request) begin
      count <= cnt_w'(reset_cycles);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // high for exactly reset_cycles cycles after the load
  assign core_reset = (count != '0);

endmodule

// File: logic/host_bridge_regs.sv
// Bridge write decode into core settings and download flags.
// Write-only: there is no read path. Unmapped addresses are ignored.
// reset_request is a combinational one-cycle decode of the reset register write.

`timescale 1ns/1ns

module host_bridge_regs
  import core_pkg::*;
(
  input  logic                 clk_74a,
  input  logic                 pll_core_locked,
  input  bridge_addr_t         bridge_addr,
  input  logic                 bridge_wr,
  input  bridge_data_t         bridge_wr_data,
  input  save_blocks_t         save_size,
  core_settings_if.regs        settings,
  output logic                 reset_request,
  output logic [1:0]           cart_download_sel,
  output logic [1:0]           bios_download,
  output logic                 save_download,
  output logic                 datatable_wren,
  output bridge_data_t         datatable_data
);

  logic cart_download;
  logic is_color_cart;
  logic bw_bios_download;
  logic color_bios_download;

  ////////////////////////////////////////
  // register writes

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      cart_download              <= 1'b0;
      is_color_cart              <= 1'b0;
      bw_bios_download           <= 1'b0;
      color_bios_download        <= 1'b0;
      save_download              <= 1'b0;
      settings.system            <= auto;
      settings.cpu_turbo         <= 1'b0;
      settings.triple_buffer     <= 1'b0;
      settings.flickerblend      <= blend_off;
      settings.orientation       <= orient_auto;
      settings.flip_horizontal   <= 1'b0;
      settings.fastforward_sound <= 1'b0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        reg_cart_download:     cart_download <= bridge_wr_data[0];
        reg_is_color_cart:     is_color_cart <= bridge_wr_data[0];
        reg_bw_bios:           bw_bios_download <= bridge_wr_data[0];
        reg_color_bios:        color_bios_download <= bridge_wr_data[0];
        reg_save_download:     save_download <= bridge_wr_data[0];
        reg_system:            settings.system <= system_e'(bridge_wr_data[1:0]);
        reg_cpu_turbo:         settings.cpu_turbo <= bridge_wr_data[0];
        reg_triple_buffer:     settings.triple_buffer <= bridge_wr_data[0];
        reg_flickerblend:      settings.flickerblend <= flickerblend_e'(bridge_wr_data[1:0]);
        reg_orientation:       settings.orientation <= orientation_e'(bridge_wr_data[1:0]);
        reg_flip_horizontal:   settings.flip_horizontal <= bridge_wr_data[0];
        reg_fastforward_sound: settings.fastforward_sound <= bridge_wr_data[0];
        default: ;
      endcase
    end
  end

  // reset is a strobe, handled by the stretcher
  assign reset_request = bridge_wr && (bridge_addr == reg_core_reset);

  // one-hot cart select: color in bit 1, mono in bit 0
  assign cart_download_sel = is_color_cart ? {cart_download, 1'b0} : {1'b0, cart_download};
  assign bios_download     = {color_bios_download, bw_bios_download};

  ////////////////////////////////////////
  // save size data table word

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      datatable_wren <= 1'b0;
      datatable_data <= '0;
    end else begin
      datatable_wren <= 1'b1;
      // blocks to bytes
      datatable_data <= bridge_data_t'(save_size) * save_block_bytes;
    end
  end

endmodule

// File: logic/core_settings_if.sv
// Decoded core settings, written only by the bridge register block.
// Combinational bundle with no clock of its own; fields hold until rewritten.

`timescale 1ns/1ns

interface core_settings_if;

  core_pkg::system_e       system;
  logic                    cpu_turbo;
  logic                    triple_buffer;
  core_pkg::flickerblend_e flickerblend;
  core_pkg::orientation_e  orientation;
  logic                    flip_horizontal;
  logic                    fastforward_sound;

  // register block side
  modport regs (
    output system, cpu_turbo, triple_buffer, flickerblend,
    output orientation, flip_horizontal, fastforward_sound
  );

  // consumers
  modport sink (
    input system, cpu_turbo, triple_buffer, flickerblend,
    input orientation, flip_horizontal, fastforward_sound
  );

endinterface

// File: logic/core_pkg.sv
// Shared register map, setting encodings and data widths for the host shell.
// Bridge addresses are decoded against the full 32-bit word.
// The save slot word is only for the host's data table and is not driven by the RTL.

package core_pkg;

  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;

  ////////////////////////////////////////
  // bridge register map

  // downloads
  localparam bridge_addr_t reg_cart_download     = 32'h000;
  localparam bridge_addr_t reg_is_color_cart     = 32'h004;
  localparam bridge_addr_t reg_bw_bios           = 32'h008;
  localparam bridge_addr_t reg_color_bios        = 32'h00C;
  localparam bridge_addr_t reg_save_download     = 32'h010;

  // system control
  localparam bridge_addr_t reg_core_reset        = 32'h050;
  localparam bridge_addr_t reg_system            = 32'h100;
  localparam bridge_addr_t reg_cpu_turbo         = 32'h110;

  // video
  localparam bridge_addr_t reg_triple_buffer     = 32'h200;
  localparam bridge_addr_t reg_flickerblend      = 32'h204;
  localparam bridge_addr_t reg_orientation       = 32'h208;
  localparam bridge_addr_t reg_flip_horizontal   = 32'h20C;

  // audio
  localparam bridge_addr_t reg_fastforward_sound = 32'h300;

  ////////////////////////////////////////
  // setting encodings

  typedef enum logic [1:0] {auto, mono, color} system_e;
  typedef enum logic [1:0] {orient_auto, orient_horizontal, orient_vertical} orientation_e;
  typedef enum logic [1:0] {blend_off, blend_2frame, blend_3frame} flickerblend_e;

  typedef logic [23:0] rgb_t;
  typedef logic [11:0] save_blocks_t;

  // save size reported in 512 byte blocks
  localparam bridge_data_t save_block_bytes = 32'd512;
  // data table word the host reads the save size from
  localparam int save_slot_word = 7;

endpackage
